// ==== Makefile ====
SRCS := $(filter %.sv,$(shell cat sources.f))

obj_dir/Vtb_tri_channel: sources.f $(SRCS)
	verilator --binary --timing --assert --top-module tb_tri_channel -f sources.f -o Vtb_tri_channel

run: obj_dir/Vtb_tri_channel
	./obj_dir/Vtb_tri_channel > sim.log 2>&1; cat sim.log
	@if grep -q "Test failures found" sim.log; then echo "Simulation FAILED"; exit 1; fi
	@grep -q "All tests passed!" sim.log || (echo "Simulation did not complete"; exit 1)

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean

// ==== apu_down_counter.sv ====
`default_nettype none

module apu_down_counter #(
	parameter type count_t = logic [7:0]
) (
	input  wire    phi1,
	input  wire    rst_n,
	input  wire    load,
	input  wire    step,
	input  count_t load_val,
	output logic   zero
);

	count_t count;

	assign zero = (count == '0);

	// Load wins over step. A zero count holds.
	always_ff @(posedge phi1 or negedge rst_n) begin
		if (!rst_n) begin
			count <= '0;
		end else if (load) begin
			count <= load_val;
		end else if (step && !zero) begin
			count <= count - 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== sources.f ====
tri_pkg.sv
apu_down_counter.sv
tri_reg_decode.sv
tri_linear_counter.sv
tri_freq_timer.sv
tri_sequencer.sv
tri_channel.sv
tri_assertions.sv
tb_tri_channel.sv

// ==== tb_tri_channel.sv ====
`default_nettype none

module tb_tri_channel import tri_pkg::*; ();

	timeunit 1ns;
	timeprecision 1ns;

	logic              phi1;
	logic              rst_n;
	logic              wr;
	logic [ADDR_W-1:0] addr;
	logic [DATA_W-1:0] data;
	logic              quarter_frame;
	logic              len_active;
	logic              lock;
	logic [OUT_W-1:0]  tri_out;
	logic              tri_halt;
	int                per;
	int                lin;

	tri_channel DUT (
		.phi1          (phi1),
		.rst_n         (rst_n),
		.wr            (wr),
		.addr          (addr),
		.data          (data),
		.quarter_frame (quarter_frame),
		.len_active    (len_active),
		.lock          (lock),
		.tri_out       (tri_out),
		.tri_halt      (tri_halt)
	);

	initial begin
		phi1 = 1'b0;
		forever #50 phi1 = ~phi1;
	end

	////////////////////////////////////////
	// Helpers
	////////////////////////////////////////

	// Triangle level for step s: falls 15..0, then rises 0..15.
	function automatic logic [OUT_W-1:0] level_of(input int s);
		int m;
		m = s % 32;
		level_of = (m < 16) ? OUT_W'(15 - m) : OUT_W'(m - 16);
	endfunction

	task automatic tick();
		@(posedge phi1);
		#10; // Drive point.
	endtask

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("Test failures found");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_out(input logic [OUT_W-1:0] act, input logic [OUT_W-1:0] exp,
		input string what);
		if (act !== exp)
			abort_run($sformatf("mismatch at %0t: %s, tri_out %0d expected %0d",
				$time, what, act, exp));
	endtask

	task automatic check_bit(input logic act, input logic exp, input string what);
		if (act !== exp)
			abort_run($sformatf("mismatch at %0t: %s, got %b expected %b", $time, what, act, exp));
	endtask

	task automatic check_gap(input int act, input int exp, input string what);
		if (act != exp)
			abort_run($sformatf("mismatch at %0t: %s, %0d cycles expected %0d",
				$time, what, act, exp));
	endtask

	task automatic bus_write(input logic [ADDR_W-1:0] a, input logic [DATA_W-1:0] d);
		wr   = 1'b1;
		addr = a;
		data = d;
		tick();
		wr = 1'b0;
	endtask

	task automatic pulse_qf();
		quarter_frame = 1'b1;
		tick();
		quarter_frame = 1'b0;
	endtask

	// Control, then both timer bytes. The high byte arms the reload flag.
	task automatic program_channel(input logic halt, input int lin_val);
		bus_write(REG_CTRL, {halt, LIN_W'(lin_val)});
		bus_write(REG_TIMER_LO, 8'(per));
		bus_write(REG_TIMER_HI, 8'(per >> 8));
		repeat (2) tick();
	endtask

	task automatic wait_change(input int limit, output int n);
		logic [OUT_W-1:0] old;
		old = tri_out;
		n = 0;
		while (tri_out === old) begin
			if (n == limit)
				abort_run($sformatf("timeout: tri_out stuck at %0d for %0d cycles", old, limit));
			tick();
			n++;
		end
	endtask

	task automatic expect_frozen(input int cycles, input string what);
		logic [OUT_W-1:0] old;
		old = tri_out;
		repeat (cycles) begin
			tick();
			check_out(tri_out, old, what);
		end
	endtask

	////////////////////////////////////////
	// Tests
	////////////////////////////////////////

	task automatic test_reset();
		check_out(tri_out, 4'd15, "reset level");
		check_bit(tri_halt, 1'b0, "reset halt");
		len_active = 1'b1;
		expect_frozen(50, "idle with zero linear count");
	endtask

	task automatic test_waveform();
		int n;
		int gap;
		int s;
		per = 2 + int'($urandom % 39);
		lin = 1 + int'($urandom % 127);
		program_channel(1'b1, lin);
		pulse_qf();
		wait_change(3 * (per + 1) + 8, n);
		check_out(tri_out, level_of(1), "first step");
		gap = 0;
		for (s = 2; s <= 33; s++) begin
			gap += per + 1;
			if (level_of(s) != level_of(s - 1)) begin // Equal levels hide a step.
				wait_change(gap + 4, n);
				check_out(tri_out, level_of(s), "waveform level");
				check_gap(n, gap, "step spacing");
				gap = 0;
			end
		end
	endtask

	task automatic test_linear_expiry();
		int n;
		int cnt;
		cnt = 1 + int'($urandom % 6);
		program_channel(1'b0, cnt);
		repeat (cnt) pulse_qf(); // Reload plus cnt-1 decrements.
		wait_change(3 * (per + 1) + 8, n);
		pulse_qf();
		expect_frozen(4 * (per + 1), "linear counter expired");
	endtask

	task automatic test_gating();
		int n;
		program_channel(1'b1, lin);
		pulse_qf();
		wait_change(3 * (per + 1) + 8, n);
		len_active = 1'b0;
		expect_frozen(4 * (per + 1), "len_active low");
		len_active = 1'b1;
		wait_change(3 * (per + 1) + 8, n);
		lock = 1'b1;
		expect_frozen(4 * (per + 1), "lock high");
		lock = 1'b0;
		wait_change(3 * (per + 1) + 8, n);
	endtask

	task automatic test_step_load();
		int vals[3] = '{3, 16, 31};
		int i;
		lock = 1'b1; // Hold the sequencer still.
		for (i = 0; i < 3; i++) begin
			bus_write(REG_TEST, 8'(vals[i]));
			tick();
			check_out(tri_out, level_of(vals[i]), "test load");
		end
		lock = 1'b0;
	endtask

	task automatic test_halt();
		int n;
		bus_write(REG_CTRL, 8'h7F); // Low bits set, control flag clear.
		check_bit(tri_halt, 1'b0, "halt with low bits set");
		program_channel(1'b1, 2);
		check_bit(tri_halt, 1'b1, "halt set");
		repeat (6) begin
			pulse_qf();
			wait_change(3 * (per + 1) + 8, n);
		end
		bus_write(REG_CTRL, 8'h00);
		check_bit(tri_halt, 1'b0, "halt cleared");
	endtask

	initial begin
		rst_n         = 1'b0;
		wr            = 1'b0;
		addr          = '0;
		data          = '0;
		quarter_frame = 1'b0;
		len_active    = 1'b0;
		lock          = 1'b0;
		per           = 0;
		lin           = 0;
		void'($urandom(32'h3faf7914));
		repeat (3) @(posedge phi1);
		#10;
		rst_n = 1'b1;
		test_reset();
		test_waveform();
		test_linear_expiry();
		test_gating();
		test_step_load();
		test_halt();
		$display("All tests passed!");
		$finish;
	end

endmodule

`default_nettype wire

// ==== tri_assertions.sv ====
`default_nettype none

module tri_assertions import tri_pkg::*; (
	input wire              phi1,
	input wire              rst_n,
	input wire              expire,
	input wire              lin_active,
	input wire              len_active,
	input wire              lock,
	input wire              test_load,
	input wire [STEP_W-1:0] step,
	input wire [OUT_W-1:0]  tri_out
);

	timeunit 1ns;
	timeprecision 1ns;

	logic             advance;
	logic [OUT_W-1:0] fold_ref;

	assign advance  = expire && lin_active && len_active && !lock;
	assign fold_ref = (step < 5'd16) ? OUT_W'(5'd15 - step) : OUT_W'(step - 5'd16);

	////////////////////////////////////////
	// Sequencer properties
	////////////////////////////////////////

	a_out_cause: assert property (@(posedge phi1) disable iff (!rst_n)
		!$past(test_load || advance) |-> $stable(tri_out))
		else $error("tri_out changed without a test load or qualified expiry");

	a_out_fold: assert property (@(posedge phi1) disable iff (!rst_n)
		tri_out == fold_ref)
		else $error("tri_out differs from the folded step");

	// Single increments only, wrapping at 32.
	a_step_inc: assert property (@(posedge phi1) disable iff (!rst_n)
		!$past(test_load) |-> STEP_W'(step - $past(step)) <= 5'd1)
		else $error("step jumped without a test load");

endmodule

bind tri_sequencer tri_assertions u_assertions (
	.phi1       (phi1),
	.rst_n      (rst_n),
	.expire     (expire),
	.lin_active (lin_active),
	.len_active (len_active),
	.lock       (lock),
	.test_load  (test_load),
	.step       (step),
	.tri_out    (tri_out)
);

`default_nettype wire

// ==== tri_channel.sv ====
`default_nettype none

module tri_channel import tri_pkg::*; (
	input  wire              phi1,
	input  wire              rst_n,
	input  wire              wr,
	input  wire [ADDR_W-1:0] addr,
	input  wire [DATA_W-1:0] data,
	input  wire              quarter_frame,
	input  wire              len_active,
	input  wire              lock,
	output logic [OUT_W-1:0] tri_out,
	output logic             tri_halt
);

	tri_regs_t regs;
	tri_wr_t   wr_evt;
	logic      lin_active;
	logic      expire;

	////////////////////////////////////////
	// Register decode
	////////////////////////////////////////

	tri_reg_decode u_decode (
		.phi1   (phi1),
		.rst_n  (rst_n),
		.wr     (wr),
		.addr   (addr),
		.data   (data),
		.regs   (regs),
		.wr_evt (wr_evt)
	);

	assign tri_halt = regs.halt;

	////////////////////////////////////////
	// Counters
	////////////////////////////////////////

	tri_linear_counter u_lin (
		.phi1          (phi1),
		.rst_n         (rst_n),
		.regs          (regs),
		.reload_set    (wr_evt.timer_hi),
		.quarter_frame (quarter_frame),
		.lin_active    (lin_active)
	);

	tri_freq_timer u_timer (
		.phi1   (phi1),
		.rst_n  (rst_n),
		.period (regs.period),
		.expire (expire)
	);

	////////////////////////////////////////
	// Output sequencer
	////////////////////////////////////////

	tri_sequencer u_seq (
		.phi1       (phi1),
		.rst_n      (rst_n),
		.expire     (expire),
		.lin_active (lin_active),
		.len_active (len_active),
		.lock       (lock),
		.test_load  (wr_evt.test),
		.test_step  (wr_evt.test_step),
		.tri_out    (tri_out)
	);

endmodule

`default_nettype wire

// ==== tri_freq_timer.sv ====
`default_nettype none

module tri_freq_timer import tri_pkg::*; (
	input  wire     phi1,
	input  wire     rst_n,
	input  period_t period,
	output logic    expire
);

	logic cnt_zero;

	////////////////////////////////////////
	// Period counter
	////////////////////////////////////////

	// Reload at zero, count down otherwise.
	// A period of P gives an expiry every P+1 cycles.
	apu_down_counter #(
		.count_t(period_t)
	) u_freq_cnt (
		.phi1     (phi1),
		.rst_n    (rst_n),
		.load     (cnt_zero),
		.step     (!cnt_zero),
		.load_val (period),
		.zero     (cnt_zero)
	);

	////////////////////////////////////////
	// Expiry pulse
	////////////////////////////////////////

	always_ff @(posedge phi1 or negedge rst_n) begin
		if (!rst_n) begin
			expire <= 1'b0;
		end else begin
			expire <= cnt_zero; // One cycle per terminal count.
		end
	end

endmodule

`default_nettype wire

// ==== tri_linear_counter.sv ====
`default_nettype none

module tri_linear_counter import tri_pkg::*; (
	input  wire       phi1,
	input  wire       rst_n,
	input  tri_regs_t regs,
	input  wire       reload_set,
	input  wire       quarter_frame,
	output logic      lin_active
);

	logic reload_flag;
	logic cnt_load;
	logic cnt_step;
	logic cnt_zero;

	////////////////////////////////////////
	// Reload flag
	////////////////////////////////////////

	// A timer-high write beats a same-cycle clear.
	always_ff @(posedge phi1 or negedge rst_n) begin
		if (!rst_n) begin
			reload_flag <= 1'b0;
		end else if (reload_set) begin
			reload_flag <= 1'b1;
		end else if (quarter_frame && !regs.halt) begin
			reload_flag <= 1'b0;
		end
	end

	////////////////////////////////////////
	// Linear count
	////////////////////////////////////////

	assign cnt_load = quarter_frame && reload_flag;
	assign cnt_step = quarter_frame && !reload_flag; // Counter ignores a step at zero.

	apu_down_counter #(
		.count_t(lin_count_t)
	) u_lin_cnt (
		.phi1     (phi1),
		.rst_n    (rst_n),
		.load     (cnt_load),
		.step     (cnt_step),
		.load_val (regs.lin_reload),
		.zero     (cnt_zero)
	);

	assign lin_active = !cnt_zero;

endmodule

`default_nettype wire

// ==== tri_pkg.sv ====
`default_nettype none

package tri_pkg;

	////////////////////////////////////////
	// Register map
	////////////////////////////////////////

	localparam int ADDR_W = 5;
	localparam int DATA_W = 8;

	localparam logic [ADDR_W-1:0] REG_CTRL     = 5'h08;
	localparam logic [ADDR_W-1:0] REG_TIMER_LO = 5'h0A;
	localparam logic [ADDR_W-1:0] REG_TIMER_HI = 5'h0B;
	localparam logic [ADDR_W-1:0] REG_TEST     = 5'h1A;

	////////////////////////////////////////
	// Field widths
	////////////////////////////////////////

	localparam int LIN_W    = 7;
	localparam int PERIOD_W = 11;
	localparam int STEP_W   = 5;
	localparam int OUT_W    = 4;

	localparam int CTRL_HALT_BIT = 7;               // Control flag in the control byte.
	localparam int TIMER_HI_W    = PERIOD_W - DATA_W; // Period bits in the high write.

	typedef logic [LIN_W-1:0]    lin_count_t;
	typedef logic [PERIOD_W-1:0] period_t;

	// Programmed channel state, 19 bits.
	typedef struct packed {
		logic       halt;
		lin_count_t lin_reload;
		period_t    period;
	} tri_regs_t;

	// One-cycle write events from the decoder.
	typedef struct packed {
		logic              ctrl;
		logic              timer_hi;
		logic              test;
		logic [STEP_W-1:0] test_step;
	} tri_wr_t;

	// Fold a sequence step into the triangle sample.
	// Steps 0..15 fall from 15 to 0, steps 16..31 rise from 0 to 15.
	function automatic logic [OUT_W-1:0] tri_fold(input logic [STEP_W-1:0] s);
		tri_fold = s[STEP_W-1] ? s[OUT_W-1:0] : ~s[OUT_W-1:0];
	endfunction

endpackage

`default_nettype wire

// ==== tri_reg_decode.sv ====
`default_nettype none

module tri_reg_decode import tri_pkg::*; (
	input  wire              phi1,
	input  wire              rst_n,
	input  wire              wr,
	input  wire [ADDR_W-1:0] addr,
	input  wire [DATA_W-1:0] data,
	output tri_regs_t        regs,
	output tri_wr_t          wr_evt
);

	logic hit_ctrl;
	logic hit_timer_lo;
	logic hit_timer_hi;
	logic hit_test;

	////////////////////////////////////////
	// Address decode
	////////////////////////////////////////

	// Unknown offsets match nothing and fall through.
	always_comb begin
		hit_ctrl     = 1'b0;
		hit_timer_lo = 1'b0;
		hit_timer_hi = 1'b0;
		hit_test     = 1'b0;
		if (wr) begin
			case (addr)
				REG_CTRL:     hit_ctrl     = 1'b1;
				REG_TIMER_LO: hit_timer_lo = 1'b1;
				REG_TIMER_HI: hit_timer_hi = 1'b1;
				REG_TEST:     hit_test     = 1'b1;
				default:      ;
			endcase
		end
	end

	////////////////////////////////////////
	// Register file
	////////////////////////////////////////

	always_ff @(posedge phi1 or negedge rst_n) begin
		if (!rst_n) begin
			regs <= '0;
		end else begin
			if (hit_ctrl) begin
				regs.halt       <= data[CTRL_HALT_BIT];
				regs.lin_reload <= data[LIN_W-1:0];
			end
			if (hit_timer_lo)
				regs.period[DATA_W-1:0] <= data; // Low byte of the period.
			if (hit_timer_hi)
				regs.period[PERIOD_W-1:DATA_W] <= data[TIMER_HI_W-1:0];
		end
	end

	// Strobes last exactly one cycle.
	always_ff @(posedge phi1 or negedge rst_n) begin
		if (!rst_n) begin
			wr_evt <= '0;
		end else begin
			wr_evt.ctrl     <= hit_ctrl;
			wr_evt.timer_hi <= hit_timer_hi;
			wr_evt.test     <= hit_test;
			if (hit_test)
				wr_evt.test_step <= data[STEP_W-1:0];
		end
	end

endmodule

`default_nettype wire

// ==== tri_sequencer.sv ====
`default_nettype none

module tri_sequencer import tri_pkg::*; (
	input  wire              phi1,
	input  wire              rst_n,
	input  wire              expire,
	input  wire              lin_active,
	input  wire              len_active,
	input  wire              lock,
	input  wire              test_load,
	input  wire [STEP_W-1:0] test_step,
	output logic [OUT_W-1:0] tri_out
);

	logic [STEP_W-1:0] step;
	logic [STEP_W-1:0] step_nxt;
	logic              step_en;

	////////////////////////////////////////
	// Step gating
	////////////////////////////////////////

	// All three qualifiers must hold on an expiry.
	assign step_en = expire && lin_active && len_active && !lock;

	always_comb begin
		step_nxt = step;
		if (test_load)
			step_nxt = test_step;           // Test load has priority.
		else if (step_en)
			step_nxt = step + 1'b1;         // Wraps at 32.
	end

	////////////////////////////////////////
	// Step and sample registers
	////////////////////////////////////////

	always_ff @(posedge phi1 or negedge rst_n) begin
		if (!rst_n) begin
			step    <= '0;
			tri_out <= {OUT_W{1'b1}}; // Fold of step 0.
		end else begin
			step    <= step_nxt;
			tri_out <= tri_fold(step_nxt);
		end
	end

endmodule

`default_nettype wire
